//--- compile.f
common/pack_pkg.sv
packer/packer_fifo.sv
hdl/word_merger.sv
hdl/dual_pack_top.sv
tb/tb_dual_pack.sv

//--- Makefile
# Verilator build for the dual stream packer

TOP := tb_dual_pack
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module dual_pack_top -f compile.f
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --top-module $(TOP) -f compile.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_dual_pack.sv
`timescale 1ns/1ps
`default_nettype none

// directed testbench for the two stream packer and merger
module tb_dual_pack
  import pack_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYC  = 8;
  // per test cycle budgets, random traffic dominates
  localparam int BUDGET_CYC  = 60 + 60 + 120 + 160 + 120 + 1500;
  localparam int WATCHDOG_NS = 2 * (RESET_CYC + BUDGET_CYC) * CLK_PERIOD;

  logic              clk_i = 1'b0;
  logic              rst_ni = 1'b0;
  logic              clr_i = 1'b0;
  logic              byte_valid_i = 1'b0;
  logic [BYTE_W-1:0] byte_data_i = '0;
  logic              byte_ready_o;
  logic              half_valid_i = 1'b0;
  logic [HALF_W-1:0] half_data_i = '0;
  logic              half_ready_o;
  logic              word_valid_o;
  logic [WORD_W-1:0] word_data_o;
  chan_e             word_chan_o;
  logic              word_ready_i = 1'b0;

  // items to offer, only ever appended
  logic [BYTE_W-1:0] byte_stim[$];
  logic [HALF_W-1:0] half_stim[$];
  int                byte_idx = 0;
  int                half_idx = 0;
  logic              ready_set = 1'b0;
  logic              rand_mode = 1'b0;

  // expected words per channel
  logic [WORD_W-1:0] exp_byte[$];
  logic [WORD_W-1:0] exp_half[$];
  logic [WORD_W-1:0] byte_acc = '0;
  logic [WORD_W-1:0] half_acc = '0;
  int                byte_cnt = 0;
  int                half_cnt = 0;
  chan_e             tag_log[$];

  // monitor bookkeeping
  int                edge_cnt = 0;
  int                byte_seen = 0;
  int                half_seen = 0;
  int                last_byte_edge = 0;
  int                rise_edge = 0;
  logic              valid_prev = 1'b0;
  logic              hold_pend = 1'b0;
  logic [WORD_W-1:0] hold_data = '0;
  chan_e             hold_chan = CH_BYTE;
  logic [WORD_W-1:0] last_word = '0;

  int                mismatch_cnt = 0;
  int                other_cnt = 0;
  logic [31:0]       lfsr = 32'hfccf_6f95;
  int                tag_base = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  dual_pack_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clr_i        (clr_i),
    .byte_valid_i (byte_valid_i),
    .byte_data_i  (byte_data_i),
    .byte_ready_o (byte_ready_o),
    .half_valid_i (half_valid_i),
    .half_data_i  (half_data_i),
    .half_ready_o (half_ready_o),
    .word_valid_o (word_valid_o),
    .word_data_o  (word_data_o),
    .word_chan_o  (word_chan_o),
    .word_ready_i (word_ready_i)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t ns: %s, got %h expected %h", $time, what, got, exp);
      mismatch_cnt++;
    end
  endtask

  // driver owns the readies, give it two edges to apply
  task automatic settle_ready(input logic v);
    ready_set = v;
    repeat (2) @(negedge clk_i);
  endtask

  // all items in, all expected words out
  task automatic wait_drain();
    while (byte_seen != byte_stim.size() || half_seen != half_stim.size() ||
           exp_byte.size() != 0 || exp_half.size() != 0 || word_valid_o) begin
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////
  // input driver
  //////////////////////////////

  always @(negedge clk_i) begin : drive_inputs
    logic go;
    // item taken at the last rising edge
    if (byte_valid_i && byte_seen > byte_idx) begin
      byte_idx++;
      byte_valid_i = 1'b0;
    end
    if (!byte_valid_i && byte_idx < byte_stim.size()) begin
      go = rand_mode ? (rand_bits(1) != 0) : 1'b1;
      byte_valid_i = go;
      byte_data_i  = byte_stim[byte_idx];
    end
    if (half_valid_i && half_seen > half_idx) begin
      half_idx++;
      half_valid_i = 1'b0;
    end
    if (!half_valid_i && half_idx < half_stim.size()) begin
      go = rand_mode ? (rand_bits(1) != 0) : 1'b1;
      half_valid_i = go;
      half_data_i  = half_stim[half_idx];
    end
    // three out of four cycles ready in random mode
    word_ready_i = rand_mode ? (rand_bits(2) != 0) : ready_set;
  end

  //////////////////////////////
  // monitor and scoreboard
  //////////////////////////////

  always @(posedge clk_i) begin : monitor
    logic [WORD_W-1:0] exp_w;
    edge_cnt++;
    if (rst_ni) begin
      // stalled slot keeps word and tag
      if (hold_pend) begin
        check_val(32'(word_valid_o), 32'd1, "word_valid_o dropped while stalled");
        check_val(word_data_o, hold_data, "word_data_o changed while stalled");
        check_val(32'(word_chan_o), 32'(hold_chan), "word_chan_o changed while stalled");
      end
      hold_pend = word_valid_o && !word_ready_i && !clr_i;
      hold_data = word_data_o;
      hold_chan = word_chan_o;
      if (word_valid_o && !valid_prev) begin
        rise_edge = edge_cnt;
      end
      valid_prev = word_valid_o;
      // output transfer, tag picks the queue
      if (word_valid_o && word_ready_i) begin
        tag_log.push_back(word_chan_o);
        last_word = word_data_o;
        if (word_chan_o == CH_BYTE && exp_byte.size() == 0) begin
          $display("ERROR at %0t ns: byte word %h came out, none expected", $time, word_data_o);
          other_cnt++;
        end else if (word_chan_o == CH_HALF && exp_half.size() == 0) begin
          $display("ERROR at %0t ns: half word %h came out, none expected", $time, word_data_o);
          other_cnt++;
        end else if (word_chan_o == CH_BYTE) begin
          exp_w = exp_byte.pop_front();
          check_val(word_data_o, exp_w, "byte channel word");
        end else begin
          exp_w = exp_half.pop_front();
          check_val(word_data_o, exp_w, "halfword channel word");
        end
      end
      // first item in the lowest bits
      if (byte_valid_i && byte_ready_o) begin
        byte_seen++;
        last_byte_edge = edge_cnt;
        byte_acc = byte_acc | (WORD_W'(byte_data_i) << (BYTE_W * byte_cnt));
        byte_cnt++;
        if (byte_cnt == BYTE_PER_WORD) begin
          exp_byte.push_back(byte_acc);
          byte_acc = '0;
          byte_cnt = 0;
        end
      end
      if (half_valid_i && half_ready_o) begin
        half_seen++;
        half_acc = half_acc | (WORD_W'(half_data_i) << (HALF_W * half_cnt));
        half_cnt++;
        if (half_cnt == HALF_PER_WORD) begin
          exp_half.push_back(half_acc);
          half_acc = '0;
          half_cnt = 0;
        end
      end
      // clear drops everything not yet out
      if (clr_i) begin
        exp_byte.delete();
        exp_half.delete();
        byte_acc = '0;
        half_acc = '0;
        byte_cnt = 0;
        half_cnt = 0;
      end
    end
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_byte_pack();
    tag_base = tag_log.size();
    settle_ready(1'b1);
    for (int i = 1; i <= 4; i++) begin
      byte_stim.push_back(8'(8'h11 * i));
    end
    wait_drain();
    // one edge in the packer, one in the merger
    check_val(32'(rise_edge - last_byte_edge), 32'd2, "word_valid_o latency after 4th byte");
    check_val(32'(tag_log.size() - tag_base), 32'd1, "byte test word count");
    check_val(32'(tag_log[tag_base]), 32'(CH_BYTE), "byte test tag");
    check_val(last_word, 32'h4433_2211, "byte test word order");
  endtask

  task automatic test_half_pack();
    tag_base = tag_log.size();
    half_stim.push_back(16'hbeef);
    half_stim.push_back(16'hcafe);
    wait_drain();
    check_val(32'(tag_log.size() - tag_base), 32'd1, "halfword test word count");
    check_val(32'(tag_log[tag_base]), 32'(CH_HALF), "halfword test tag");
    check_val(last_word, 32'hcafe_beef, "halfword test word order");
  endtask

  task automatic test_round_robin();
    tag_base = tag_log.size();
    settle_ready(1'b0);
    // two bytes ahead so both packers fill on the same edge
    byte_stim.push_back(8'h30);
    byte_stim.push_back(8'h31);
    while (byte_seen != byte_stim.size()) @(negedge clk_i);
    for (int i = 0; i < 2; i++) begin
      byte_stim.push_back(8'(8'h32 + i));
      half_stim.push_back(16'(16'h7100 + i));
    end
    // second words wait behind the stalled slot
    for (int i = 0; i < 4; i++) begin
      byte_stim.push_back(8'(8'h40 + i));
    end
    for (int i = 2; i < 4; i++) begin
      half_stim.push_back(16'(16'h7100 + i));
    end
    // first tie after reset lands in the slot
    while (!word_valid_o) @(negedge clk_i);
    while (byte_ready_o || half_ready_o) @(negedge clk_i);
    settle_ready(1'b1);
    wait_drain();
    check_val(32'(tag_log.size() - tag_base), 32'd4, "round robin word count");
    for (int i = 0; i < 4; i++) begin
      check_val(32'(tag_log[tag_base + i]), (i % 2 == 0) ? 32'(CH_BYTE) : 32'(CH_HALF),
                "round robin tag order");
    end
  endtask

  task automatic test_back_pressure();
    int b;
    int h;
    settle_ready(1'b0);
    for (int i = 0; i < 12; i++) begin
      byte_stim.push_back(8'(8'ha0 + i));
    end
    for (int i = 0; i < 6; i++) begin
      half_stim.push_back(16'(16'h5000 + i));
    end
    while (byte_ready_o || half_ready_o) @(negedge clk_i);
    b = byte_seen;
    h = half_seen;
    repeat (6) begin
      @(negedge clk_i);
      check_val(32'(byte_ready_o), 32'd0, "byte_ready_o high while stalled");
      check_val(32'(half_ready_o), 32'd0, "half_ready_o high while stalled");
      check_val(32'(word_valid_o), 32'd1, "word_valid_o low while stalled");
    end
    check_val(32'(byte_seen), 32'(b), "bytes taken during stall");
    check_val(32'(half_seen), 32'(h), "halfwords taken during stall");
    settle_ready(1'b1);
    wait_drain();
  endtask

  task automatic test_clear();
    tag_base = tag_log.size();
    settle_ready(1'b0);
    // one full word in the slot, two bytes partial
    for (int i = 1; i <= 6; i++) begin
      byte_stim.push_back(8'(i));
    end
    while (byte_seen != byte_stim.size() || !word_valid_o) @(negedge clk_i);
    clr_i = 1'b1;
    @(negedge clk_i);
    clr_i = 1'b0;
    check_val(32'(word_valid_o), 32'd0, "word_valid_o after clear");
    settle_ready(1'b1);
    repeat (6) begin
      @(negedge clk_i);
      check_val(32'(word_valid_o), 32'd0, "word_valid_o after clear");
    end
    check_val(32'(tag_log.size() - tag_base), 32'd0, "words out after clear");
    for (int i = 1; i <= 4; i++) begin
      byte_stim.push_back(8'(8'hc0 + i));
    end
    wait_drain();
    check_val(last_word, 32'hc4c3_c2c1, "first word after clear");
  endtask

  task automatic test_random();
    for (int i = 0; i < 48; i++) begin
      byte_stim.push_back(8'(rand_bits(8)));
    end
    for (int i = 0; i < 24; i++) begin
      half_stim.push_back(16'(rand_bits(16)));
    end
    rand_mode = 1'b1;
    while (byte_seen != byte_stim.size() || half_seen != half_stim.size()) begin
      @(negedge clk_i);
    end
    rand_mode = 1'b0;
    settle_ready(1'b1);
    wait_drain();
  endtask

  //////////////////////////////
  // sequence and end of run
  //////////////////////////////

  initial begin : run_tests
    repeat (RESET_CYC) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val(32'(byte_ready_o), 32'd1, "byte_ready_o after reset");
    check_val(32'(half_ready_o), 32'd1, "half_ready_o after reset");
    check_val(32'(word_valid_o), 32'd0, "word_valid_o after reset");
    // grant state still at its reset value here
    test_round_robin();
    test_byte_pack();
    test_half_pack();
    test_back_pressure();
    test_clear();
    test_random();
    if (exp_byte.size() != 0 || exp_half.size() != 0) begin
      $display("ERROR: %0d byte and %0d halfword words were expected but never came out",
               exp_byte.size(), exp_half.size());
      other_cnt++;
    end
    $display("value mismatches %0d, other errors %0d", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("ERROR: run timed out after %0d ns, a test stopped making progress", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule : tb_dual_pack

`default_nettype wire

//--- hdl/dual_pack_top.sv
`timescale 1ns/1ps
`default_nettype none

// two narrow streams packed to 32 bit words and merged into one
module dual_pack_top
  import pack_pkg::*;
(
  input  wire                clk_i,
  input  wire                rst_ni,

  input  wire                clr_i,

  // byte input stream
  input  wire                byte_valid_i,
  input  wire  [BYTE_W-1:0]  byte_data_i,
  output logic               byte_ready_o,

  // halfword input stream
  input  wire                half_valid_i,
  input  wire  [HALF_W-1:0]  half_data_i,
  output logic               half_ready_o,

  // merged word stream
  output logic               word_valid_o,
  output logic [WORD_W-1:0]  word_data_o,
  output chan_e              word_chan_o,
  input  wire                word_ready_i
);

  // packer to merger
  logic              byte_rvalid;
  logic [WORD_W-1:0] byte_rdata;
  logic              byte_rready;
  logic              half_rvalid;
  logic [WORD_W-1:0] half_rdata;
  logic              half_rready;

  //////////////////////////////
  // packers
  //////////////////////////////

  // four bytes per word
  packer_fifo #(
    .InW  (BYTE_W),
    .OutW (BYTE_W * BYTE_PER_WORD)
  ) u_byte_packer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (clr_i),
    .wvalid_i (byte_valid_i),
    .wdata_i  (byte_data_i),
    .wready_o (byte_ready_o),
    .rvalid_o (byte_rvalid),
    .rdata_o  (byte_rdata),
    .rready_i (byte_rready),
    .depth_o  ()
  );

  // two halfwords per word
  packer_fifo #(
    .InW  (HALF_W),
    .OutW (HALF_W * HALF_PER_WORD)
  ) u_half_packer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (clr_i),
    .wvalid_i (half_valid_i),
    .wdata_i  (half_data_i),
    .wready_o (half_ready_o),
    .rvalid_o (half_rvalid),
    .rdata_o  (half_rdata),
    .rready_i (half_rready),
    .depth_o  ()
  );

  //////////////////////////////
  // merger
  //////////////////////////////

  word_merger u_merger (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clr_i        (clr_i),
    .byte_valid_i (byte_rvalid),
    .byte_word_i  (byte_rdata),
    .byte_ready_o (byte_rready),
    .half_valid_i (half_rvalid),
    .half_word_i  (half_rdata),
    .half_ready_o (half_rready),
    .word_valid_o (word_valid_o),
    .word_data_o  (word_data_o),
    .word_chan_o  (word_chan_o),
    .word_ready_i (word_ready_i)
  );

endmodule : dual_pack_top

`default_nettype wire

//--- hdl/word_merger.sv
`timescale 1ns/1ps
`default_nettype none

// merges full words from the byte and halfword packers
// round-robin grant, one registered output slot with source tag
module word_merger
  import pack_pkg::*;
(
  input  wire                clk_i,
  input  wire                rst_ni,

  input  wire                clr_i,

  // byte packer read side
  input  wire                byte_valid_i,
  input  wire  [WORD_W-1:0]  byte_word_i,
  output logic               byte_ready_o,

  // halfword packer read side
  input  wire                half_valid_i,
  input  wire  [WORD_W-1:0]  half_word_i,
  output logic               half_ready_o,

  // merged stream
  output logic               word_valid_o,
  output logic [WORD_W-1:0]  word_data_o,
  output chan_e              word_chan_o,
  input  wire                word_ready_i
);

  // last granted channel
  chan_e             last_q;

  // output slot
  logic              slot_valid_q;
  logic [WORD_W-1:0] slot_data_q;
  chan_e             slot_chan_q;

  // arbitration
  logic              can_load;
  logic              gnt_any;
  chan_e             gnt_chan;
  logic [WORD_W-1:0] gnt_word;

  //////////////////////////////
  // arbitration
  //////////////////////////////

  // slot free now or drained this cycle
  assign can_load = !slot_valid_q || word_ready_i;

  always_comb begin
    gnt_any  = 1'b0;
    gnt_chan = CH_BYTE;
    if (can_load && !clr_i) begin
      if (byte_valid_i && half_valid_i) begin
        // both pending, the other channel goes next
        gnt_any = 1'b1;
        if (last_q == CH_BYTE) begin
          gnt_chan = CH_HALF;
        end else begin
          gnt_chan = CH_BYTE;
        end
      end else if (byte_valid_i) begin
        gnt_any  = 1'b1;
        gnt_chan = CH_BYTE;
      end else if (half_valid_i) begin
        gnt_any  = 1'b1;
        gnt_chan = CH_HALF;
      end
    end
  end

  // at most one ready high
  assign byte_ready_o = gnt_any && (gnt_chan == CH_BYTE);
  assign half_ready_o = gnt_any && (gnt_chan == CH_HALF);

  // word of the granted packer
  assign gnt_word = (gnt_chan == CH_HALF) ? half_word_i : byte_word_i;

  //////////////////////////////
  // control state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // byte channel wins the first tie
      last_q       <= CH_HALF;
      slot_valid_q <= 1'b0;
    end else if (clr_i) begin
      slot_valid_q <= 1'b0;
    end else if (gnt_any) begin
      last_q       <= gnt_chan;
      slot_valid_q <= 1'b1;
    end else if (word_ready_i) begin
      // drained with nothing behind it
      slot_valid_q <= 1'b0;
    end
  end

  // slot payload and tag
  always_ff @(posedge clk_i) begin
    if (gnt_any) begin
      slot_data_q <= gnt_word;
      slot_chan_q <= gnt_chan;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign word_valid_o = slot_valid_q;
  assign word_data_o  = slot_data_q;
  assign word_chan_o  = slot_chan_q;

endmodule : word_merger

`default_nettype wire

//--- packer/packer_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// width converting single word FIFO
// InW < OutW packs narrow items into one wide word, first item lowest
// InW >= OutW unpacks one wide word into narrow slices, lowest first
//
// pack mode, InW = 8, OutW = 32
//   wvalid_i  _|~~~~~~~~~~~~~~~|_______
//   wready_o  ~~~~~~~~~~~~~~~~~|___|~~~
//   depth_o    0 | 1 | 2 | 3 | 4 | 0
//   rvalid_o  _________________|~~~|___
//   rready_i  _________________|~~~|___
module packer_fifo #(
  parameter int InW  = 8,
  parameter int OutW = 32,
  // derived sizes
  localparam int MaxW   = (InW > OutW) ? InW : OutW,
  localparam int MinW   = (InW < OutW) ? InW : OutW,
  localparam int Ratio  = MaxW / MinW,
  localparam int DepthW = $clog2(Ratio)
) (
  input  wire              clk_i,
  input  wire              rst_ni,

  input  wire              clr_i,

  // narrow or wide write side
  input  wire              wvalid_i,
  input  wire  [InW-1:0]   wdata_i,
  output logic             wready_o,

  // read side
  output logic             rvalid_o,
  output logic [OutW-1:0]  rdata_o,
  input  wire              rready_i,

  // items held in pack mode, slices left in unpack mode
  output logic [DepthW:0]  depth_o
);

  // depth value when the word is complete
  localparam logic [DepthW:0] FullDepth = (DepthW+1)'(Ratio);

  logic [DepthW:0] depth_q, depth_d;
  logic [MaxW-1:0] data_q, data_d;
  logic            load_data;
  logic            pull_data;

  // handshakes on both sides
  assign load_data = wvalid_i && wready_o;
  assign pull_data = rvalid_o && rready_i;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      depth_q <= '0;
    end else begin
      depth_q <= depth_d;
    end
  end

  // word storage, qualified by depth
  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  assign depth_o = depth_q;

  if (InW < OutW) begin : gen_pack_mode

    //////////////////////////////
    // pack narrow into wide
    //////////////////////////////

    logic [MaxW-1:0] wdata_shifted;

    // item lands above the ones already held
    assign wdata_shifted = MaxW'(wdata_i) << (depth_q * InW);

    always_comb begin
      depth_d = depth_q;
      data_d  = data_q;
      if (clr_i || pull_data) begin
        // word consumed or dropped
        depth_d = '0;
      end else if (load_data) begin
        depth_d = depth_q + 1'b1;
        // first item starts a fresh word
        if (depth_q == '0) begin
          data_d = wdata_shifted;
        end else begin
          data_d = data_q | wdata_shifted;
        end
      end
    end

    // stall input while the full word waits
    assign wready_o = (depth_q != FullDepth);
    assign rvalid_o = (depth_q == FullDepth);
    assign rdata_o  = data_q;

  end else begin : gen_unpack_mode

    //////////////////////////////
    // unpack wide into narrow
    //////////////////////////////

    logic [DepthW:0] ptr_q, ptr_d;

    // index of the slice on rdata_o
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_d;
      end
    end

    always_comb begin
      depth_d = depth_q;
      ptr_d   = ptr_q;
      data_d  = data_q;
      if (clr_i) begin
        depth_d = '0;
        ptr_d   = '0;
      end else if (load_data) begin
        // whole word in, all slices pending
        depth_d = FullDepth;
        ptr_d   = '0;
        data_d  = MaxW'(wdata_i);
      end else if (pull_data) begin
        depth_d = depth_q - 1'b1;
        ptr_d   = ptr_q + 1'b1;
      end
    end

    // accept a new word only once empty
    assign wready_o = (depth_q == '0);
    assign rvalid_o = (depth_q != '0);
    assign rdata_o  = OutW'(data_q >> (ptr_q * OutW));

  end

endmodule : packer_fifo

`default_nettype wire

//--- common/pack_pkg.sv
`default_nettype none

package pack_pkg;

  //////////////////////////////
  // datapath widths
  //////////////////////////////

  // merged output word
  localparam int WORD_W = 32;

  // narrow item on the byte channel
  localparam int BYTE_W = 8;

  // narrow item on the halfword channel
  localparam int HALF_W = 16;

  // items needed to fill one output word
  localparam int BYTE_PER_WORD = WORD_W / BYTE_W;
  localparam int HALF_PER_WORD = WORD_W / HALF_W;

  //////////////////////////////
  // channel tag
  //////////////////////////////

  // source of a merged word
  // also the round-robin grant state in the merger
  typedef enum logic [0:0] {
    CH_BYTE = 1'b0,
    CH_HALF = 1'b1
  } chan_e;

endpackage : pack_pkg

`default_nettype wire
